//--- rtl/mulDivPkg.sv
package mulDivPkg;

  //////////////////////////////
  // Widths and divider pacing
  //////////////////////////////

  // Data width of the integer datapath
  localparam int Xlen = 32;

  // Quotient bits retired per cycle, must divide Xlen evenly
  localparam int DivBits = 2;

  // Number of iteration cycles for a full quotient
  localparam int DivSteps = Xlen / DivBits;

  // Step counter only needs to reach DivSteps-1
  localparam int StepBits = $clog2(DivSteps);
  localparam logic [StepBits-1:0] LastStep = StepBits'(DivSteps - 1);

  //////////////////////////////
  // Operation encoding
  //////////////////////////////

  // Bit 2 selects the divider, for divisions bit 0 means unsigned and bit 1 means remainder
  // The multiply codes follow the RISC-V funct3 order
  typedef enum logic [2:0] {
    Mul    = 3'b000,
    Mulh   = 3'b001,
    Mulhsu = 3'b010,
    Mulhu  = 3'b011,
    Div    = 3'b100,
    Divu   = 3'b101,
    Rem    = 3'b110,
    Remu   = 3'b111
  } mulDivOp_t;

  // One request as presented on the issue port
  typedef struct packed {
    mulDivOp_t        op;
    logic [Xlen-1:0]  srcA;
    logic [Xlen-1:0]  srcB;
  } mulDivReq_t;

  // Divider output before sign correction and divide by zero handling
  typedef struct packed {
    logic [Xlen-1:0]  quot;
    logic [Xlen-1:0]  rem;
    logic [Xlen-1:0]  dividend;
    logic             negQuot;
    logic             negRem;
    logic             divZero;
    logic             wantRem;
  } divResult_t;

  // Full product plus the half the operation wants
  typedef struct packed {
    logic [2*Xlen-1:0] product;
    logic              wantHigh;
  } mulResult_t;

endpackage

//--- rtl/pipelinedMultiplier.sv
`timescale 1ns/1ps

module pipelinedMultiplier (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  logic [mulDivPkg::Xlen-1:0]  srcA,
  input  logic [mulDivPkg::Xlen-1:0]  srcB,
  input  logic                        signA,
  input  logic                        signB,
  input  logic                        wantHigh,
  output logic                        done,
  output mulDivPkg::mulResult_t       res
);

  // Operands grow by one bit so a single signed multiplier covers every signedness mix
  logic [mulDivPkg::Xlen:0]      aExt;
  logic [mulDivPkg::Xlen:0]      bExt;
  logic [mulDivPkg::Xlen:0]      aReg;
  logic [mulDivPkg::Xlen:0]      bReg;
  logic                          highReg;
  logic                          valid1;
  logic [2*mulDivPkg::Xlen+1:0]  fullProduct;

  //////////////////////////////
  // Stage one
  //////////////////////////////

  // An unsigned operand gets a zero on top, a signed one copies its sign bit
  assign aExt = {signA & srcA[mulDivPkg::Xlen-1], srcA};
  assign bExt = {signB & srcB[mulDivPkg::Xlen-1], srcB};

  // Valid bit tracks the issue strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      valid1 <= 1'b0;
    end else begin
      valid1 <= start;
    end
  end

  // Operand registers load on every issue and hold otherwise
  always_ff @(posedge clk) begin
    if (start) begin
      aReg    <= aExt;
      bReg    <= bExt;
      highReg <= wantHigh;
    end
  end

  //////////////////////////////
  // Stage two
  //////////////////////////////

  // The 66-bit signed product always fits, and the top two bits are redundant
  assign fullProduct = $signed(aReg) * $signed(bReg);

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= valid1;
    end
  end

  // Only the low 64 bits are kept along with the half select
  always_ff @(posedge clk) begin
    if (valid1) begin
      res.product  <= fullProduct[2*mulDivPkg::Xlen-1:0];
      res.wantHigh <= highReg;
    end
  end

endmodule

//--- rtl/restoringDivider.sv
`timescale 1ns/1ps

module restoringDivider (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  logic [mulDivPkg::Xlen-1:0]  srcA,
  input  logic [mulDivPkg::Xlen-1:0]  srcB,
  input  logic                        signedOp,
  input  logic                        wantRem,
  output logic                        busy,
  output logic                        done,
  output mulDivPkg::divResult_t       res
);

  // Partial remainder and dividend/quotient shift register per step
  logic [mulDivPkg::Xlen-1:0]        wStep  [mulDivPkg::DivBits+1];
  logic [mulDivPkg::Xlen-1:0]        xqStep [mulDivPkg::DivBits+1];

  // Absolute values and negated divisor computed at issue
  logic [mulDivPkg::Xlen-1:0]        aAbs;
  logic [mulDivPkg::Xlen-1:0]        bAbs;
  logic [mulDivPkg::Xlen-1:0]        dNeg;

  // Registered iteration state
  logic [mulDivPkg::Xlen-1:0]        wReg;
  logic [mulDivPkg::Xlen-1:0]        xqReg;
  logic [mulDivPkg::Xlen-1:0]        dNegReg;
  logic [mulDivPkg::Xlen-1:0]        dividendReg;
  logic                              negQuotReg;
  logic                              negRemReg;
  logic                              zeroReg;
  logic                              wantRemReg;
  logic [mulDivPkg::StepBits-1:0]    step;

  //////////////////////////////
  // Operand preparation
  //////////////////////////////

  // Signed operations work on magnitudes and fix the signs afterwards
  always_comb begin
    aAbs = (signedOp & srcA[mulDivPkg::Xlen-1]) ? -srcA : srcA;
    bAbs = (signedOp & srcB[mulDivPkg::Xlen-1]) ? -srcB : srcB;
    // Stored negated so each trial subtraction becomes an add
    dNeg = -bAbs;
  end

  // Payload registers load at issue and then follow the iteration
  always_ff @(posedge clk) begin
    if (start) begin
      wReg        <= '0;
      xqReg       <= aAbs;
      dNegReg     <= dNeg;
      dividendReg <= srcA;
      // Quotient is negative when exactly one operand is negative
      negQuotReg  <= signedOp & (srcA[mulDivPkg::Xlen-1] ^ srcB[mulDivPkg::Xlen-1]);
      // Remainder takes the sign of the dividend
      negRemReg   <= signedOp & srcA[mulDivPkg::Xlen-1];
      zeroReg     <= (srcB == '0);
      wantRemReg  <= wantRem;
    end else if (busy) begin
      wReg  <= wStep[mulDivPkg::DivBits];
      xqReg <= xqStep[mulDivPkg::DivBits];
    end
  end

  //////////////////////////////
  // Restoring steps
  //////////////////////////////

  assign wStep[0]  = wReg;
  assign xqStep[0] = xqReg;

  // One shift and trial subtract per quotient bit, chained within a cycle
  for (genvar i = 0; i < mulDivPkg::DivBits; i++) begin : gStep
    logic [mulDivPkg::Xlen:0] shifted;
    logic [mulDivPkg::Xlen:0] trial;

    // Next dividend bit moves into the partial remainder
    assign shifted = {wStep[i], xqStep[i][mulDivPkg::Xlen-1]};
    // Adding the negated divisor with a one on top is a 33-bit subtract
    assign trial   = shifted + {1'b1, dNegReg};
    // A clear top bit means the subtraction did not borrow
    assign wStep[i+1]  = trial[mulDivPkg::Xlen] ? shifted[mulDivPkg::Xlen-1:0]
                                                : trial[mulDivPkg::Xlen-1:0];
    // Quotient bits enter at the bottom as the dividend leaves the top
    assign xqStep[i+1] = {xqStep[i][mulDivPkg::Xlen-2:0], ~trial[mulDivPkg::Xlen]};
  end

  //////////////////////////////
  // Step sequencing
  //////////////////////////////

  // Issue starts the count, the last step or a zero divisor finishes it
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        // Divide by zero skips the iteration and finishes after one cycle
        if (zeroReg || step == mulDivPkg::LastStep) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  // Raw magnitudes and correction flags go to the selector
  assign res.quot     = xqReg;
  assign res.rem      = wReg;
  assign res.dividend = dividendReg;
  assign res.negQuot  = negQuotReg;
  assign res.negRem   = negRemReg;
  assign res.divZero  = zeroReg;
  assign res.wantRem  = wantRemReg;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Each division produces exactly one done pulse
  doneSinglePulse: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  ) else $error("divider done held for two cycles");

  // A new division must wait until the previous one has finished
  noStartWhileBusy: assert property (
    @(posedge clk) disable iff (reset) start |-> !busy
  ) else $error("divider start accepted while busy");

endmodule

//--- rtl/resultSelect.sv
`timescale 1ns/1ps

module resultSelect (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        mulDone,
  input  mulDivPkg::mulResult_t       mulRes,
  input  logic                        divDone,
  input  mulDivPkg::divResult_t       divRes,
  output logic                        valid,
  output logic [mulDivPkg::Xlen-1:0]  result
);

  logic [mulDivPkg::Xlen-1:0] mulHalf;
  logic [mulDivPkg::Xlen-1:0] quotient;
  logic [mulDivPkg::Xlen-1:0] remainder;
  logic [mulDivPkg::Xlen-1:0] chosen;

  //////////////////////////////
  // Result choice
  //////////////////////////////

  always_comb begin
    // MULH variants want bits 63:32, MUL wants the low word
    mulHalf = mulRes.wantHigh ? mulRes.product[2*mulDivPkg::Xlen-1:mulDivPkg::Xlen]
                              : mulRes.product[mulDivPkg::Xlen-1:0];
    // Divide by zero gives all ones and hands back the dividend as remainder
    if (divRes.divZero) begin
      quotient  = '1;
      remainder = divRes.dividend;
    end else begin
      quotient  = divRes.negQuot ? -divRes.quot : divRes.quot;
      remainder = divRes.negRem ? -divRes.rem : divRes.rem;
    end
    // Signed overflow needs no special case, the magnitude wraps to the dividend
    if (divDone) begin
      chosen = divRes.wantRem ? remainder : quotient;
    end else begin
      chosen = mulHalf;
    end
  end

  // Valid is a single-cycle pulse following either engine
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= mulDone | divDone;
    end
  end

  // Result data only moves when there is something to report
  always_ff @(posedge clk) begin
    if (mulDone | divDone) begin
      result <= chosen;
    end
  end

  // The divider minimum latency keeps the two engines from finishing together
  noDoneCollision: assert property (
    @(posedge clk) disable iff (reset) !(mulDone && divDone)
  ) else $error("multiplier and divider finished in the same cycle");

endmodule

//--- rtl/mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  mulDivPkg::mulDivReq_t       req,
  output logic                        busy,
  output logic                        resultValid,
  output logic [mulDivPkg::Xlen-1:0]  result
);

  logic                     mulStart;
  logic                     divStart;
  logic                     signA;
  logic                     signB;
  logic                     wantHigh;
  logic                     mulDone;
  logic                     divDone;
  mulDivPkg::mulResult_t    mulRes;
  mulDivPkg::divResult_t    divRes;

  //////////////////////////////
  // Operation decode
  //////////////////////////////

  // Bit 2 of the code steers the strobe to one engine
  assign mulStart = start & ~req.op[2];
  assign divStart = start & req.op[2];

  // Only MULHU treats srcA as unsigned, and MULHSU also treats srcB as unsigned
  assign signA    = (req.op != mulDivPkg::Mulhu);
  assign signB    = (req.op == mulDivPkg::Mul) || (req.op == mulDivPkg::Mulh);
  assign wantHigh = (req.op != mulDivPkg::Mul);

  pipelinedMultiplier mul0 (
    .clk(clk), .reset(reset), .start(mulStart),
    .srcA(req.srcA), .srcB(req.srcB),
    .signA(signA), .signB(signB), .wantHigh(wantHigh),
    .done(mulDone), .res(mulRes)
  );

  // For divisions bit 0 means unsigned and bit 1 selects the remainder
  restoringDivider div0 (
    .clk(clk), .reset(reset), .start(divStart),
    .srcA(req.srcA), .srcB(req.srcB),
    .signedOp(~req.op[0]), .wantRem(req.op[1]),
    .busy(busy), .done(divDone), .res(divRes)
  );

  resultSelect sel0 (
    .clk(clk), .reset(reset),
    .mulDone(mulDone), .mulRes(mulRes),
    .divDone(divDone), .divRes(divRes),
    .valid(resultValid), .result(result)
  );

  // Nothing may be issued while a division is running
  noIssueWhileBusy: assert property (
    @(posedge clk) disable iff (reset) start |-> !busy
  ) else $error("operation issued while the unit is busy");

endmodule

//--- testbench/mulDivCases.svh
`ifndef MULDIVCASES_SVH
`define MULDIVCASES_SVH

// Columns are test name, operation, srcA, srcB and expected result
task automatic loadCases;
  // Low and high product halves, including mixed signedness
  addCase("mul small",          mulDivPkg::Mul,    32'h0000_0007, 32'h0000_0006, 32'h0000_002A);
  addCase("mul minus by plus",  mulDivPkg::Mul,    32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA);
  addCase("mul wraps to zero",  mulDivPkg::Mul,    32'h0001_0000, 32'h0001_0000, 32'h0000_0000);
  addCase("mul minus one sq",   mulDivPkg::Mul,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
  addCase("mulh minus by plus", mulDivPkg::Mulh,   32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF);
  addCase("mulh minus one sq",  mulDivPkg::Mulh,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
  // The most negative value squared is 2^62
  addCase("mulh min squared",   mulDivPkg::Mulh,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
  // srcB is unsigned so 0x80000000 counts as 2^31 here
  addCase("mulhsu plus by big", mulDivPkg::Mulhsu, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001);
  addCase("mulhsu minus by big", mulDivPkg::Mulhsu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
  addCase("mulhu max squared",  mulDivPkg::Mulhu,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
  addCase("mulhu carry out",    mulDivPkg::Mulhu,  32'h8000_0000, 32'h0000_0002, 32'h0000_0001);
  addCase("mulhu wide",         mulDivPkg::Mulhu,  32'h0001_0000, 32'h0001_0000, 32'h0000_0001);

  //////////////////////////////
  // Division on all four sign combinations, 20 and 6 in each
  addCase("div pos pos",        mulDivPkg::Div,    32'h0000_0014, 32'h0000_0006, 32'h0000_0003);
  addCase("rem pos pos",        mulDivPkg::Rem,    32'h0000_0014, 32'h0000_0006, 32'h0000_0002);
  addCase("div neg pos",        mulDivPkg::Div,    32'hFFFF_FFEC, 32'h0000_0006, 32'hFFFF_FFFD);
  addCase("rem neg pos",        mulDivPkg::Rem,    32'hFFFF_FFEC, 32'h0000_0006, 32'hFFFF_FFFE);
  addCase("div pos neg",        mulDivPkg::Div,    32'h0000_0014, 32'hFFFF_FFFA, 32'hFFFF_FFFD);
  addCase("rem pos neg",        mulDivPkg::Rem,    32'h0000_0014, 32'hFFFF_FFFA, 32'h0000_0002);
  addCase("div neg neg",        mulDivPkg::Div,    32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'h0000_0003);
  addCase("rem neg neg",        mulDivPkg::Rem,    32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'hFFFF_FFFE);
  // Same bit patterns read as unsigned magnitudes
  addCase("divu big by six",    mulDivPkg::Divu,   32'hFFFF_FFEC, 32'h0000_0006, 32'h2AAA_AAA7);
  addCase("remu big by six",    mulDivPkg::Remu,   32'hFFFF_FFEC, 32'h0000_0006, 32'h0000_0002);
  addCase("divu small",         mulDivPkg::Divu,   32'h0000_0064, 32'h0000_0007, 32'h0000_000E);
  addCase("remu small",         mulDivPkg::Remu,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002);

  //////////////////////////////
  // Divide by zero and signed overflow
  addCase("div by zero",        mulDivPkg::Div,    32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF);
  addCase("divu by zero",       mulDivPkg::Divu,   32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF);
  addCase("rem by zero",        mulDivPkg::Rem,    32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
  addCase("remu by zero",       mulDivPkg::Remu,   32'hFFFF_FFEC, 32'h0000_0000, 32'hFFFF_FFEC);
  addCase("div overflow",       mulDivPkg::Div,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
  addCase("rem overflow",       mulDivPkg::Rem,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
endtask

`endif

//--- testbench/mulDivTb.sv
`timescale 1ns/1ps

module mulDivTb;

  // Cycles allowed between issue and result before giving up
  localparam int ResultTimeout = 100;

  logic                        clk;
  logic                        reset;
  logic                        start;
  mulDivPkg::mulDivReq_t       req;
  logic                        busy;
  logic                        resultValid;
  logic [mulDivPkg::Xlen-1:0]  result;
  integer                      seed;

  // Directed table, one entry per queue index
  string                       caseName [$];
  mulDivPkg::mulDivOp_t        caseOp [$];
  logic [mulDivPkg::Xlen-1:0]  caseA [$];
  logic [mulDivPkg::Xlen-1:0]  caseB [$];
  logic [mulDivPkg::Xlen-1:0]  caseExpected [$];

  mulDivUnit dut0 (
    .clk(clk), .reset(reset), .start(start), .req(req),
    .busy(busy), .resultValid(resultValid), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic addCase(input string name, input mulDivPkg::mulDivOp_t op,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] expected);
    caseName.push_back(name);
    caseOp.push_back(op);
    caseA.push_back(a);
    caseB.push_back(b);
    caseExpected.push_back(expected);
  endtask

  `include "mulDivCases.svh"

  // Stops the run at the first mismatch
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic reportTimeout(input string name);
    $display("no result arrived within %0d cycles for %s", ResultTimeout, name);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // RISC-V product rule: extend each operand by its signedness, keep the wanted half
  function automatic logic [31:0] productHalf(input mulDivPkg::mulDivOp_t op,
                                              input logic [31:0] a, input logic [31:0] b);
    logic [63:0] aWide;
    logic [63:0] bWide;
    logic [63:0] product;
    aWide = (op == mulDivPkg::Mulhu) ? {32'b0, a} : {{32{a[31]}}, a};
    bWide = (op == mulDivPkg::Mul || op == mulDivPkg::Mulh) ? {{32{b[31]}}, b} : {32'b0, b};
    product = aWide * bWide;
    return (op == mulDivPkg::Mul) ? product[31:0] : product[63:32];
  endfunction

  // Issues one table entry and waits for its result
  task automatic runCase(input int idx);
    int  waited;
    logic isDiv;
    isDiv = caseOp[idx][2];
    req.op   = caseOp[idx];
    req.srcA = caseA[idx];
    req.srcB = caseB[idx];
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    // Divider raises busy right at the issue edge
    checkValue($sformatf("%s busy after start", caseName[idx]), {31'b0, isDiv}, {31'b0, busy});
    waited = 1;
    while (!resultValid && waited < ResultTimeout) begin
      if (!isDiv)
        checkValue($sformatf("%s busy during multiply", caseName[idx]), 32'd0, {31'b0, busy});
      @(negedge clk);
      waited++;
    end
    if (!resultValid) begin
      reportTimeout(caseName[idx]);
    end else begin
      checkValue($sformatf("%s busy at result", caseName[idx]), 32'd0, {31'b0, busy});
      checkValue(caseName[idx], caseExpected[idx], result);
    end
  endtask

  // Eight multiplies on consecutive cycles, each result exactly three cycles later
  task automatic runBurst;
    logic [31:0]          burstExpected [8];
    logic [31:0]          a;
    logic [31:0]          b;
    logic [1:0]           pick;
    mulDivPkg::mulDivOp_t op;
    for (int k = 0; k < 11; k++) begin
      if (k >= 3) begin
        checkValue($sformatf("burst %0d valid", k - 3), 32'd1, {31'b0, resultValid});
        checkValue($sformatf("burst %0d result", k - 3), burstExpected[k-3], result);
      end else begin
        checkValue($sformatf("burst idle %0d valid", k), 32'd0, {31'b0, resultValid});
      end
      checkValue($sformatf("burst %0d busy", k), 32'd0, {31'b0, busy});
      if (k < 8) begin
        a    = $random(seed);
        b    = $random(seed);
        pick = $random(seed);
        op   = mulDivPkg::mulDivOp_t'({1'b0, pick});
        burstExpected[k] = productHalf(op, a, b);
        req.op   = op;
        req.srcA = a;
        req.srcB = b;
        start    = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
    end
    // Nothing more may come out once the burst has drained
    checkValue("burst drained valid", 32'd0, {31'b0, resultValid});
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed  = 32'ha518_1690;
    reset = 1'b1;
    start = 1'b0;
    req   = '0;
    loadCases();
    repeat (16) @(negedge clk);
    reset = 1'b0;
    checkValue("busy after reset", 32'd0, {31'b0, busy});
    checkValue("valid after reset", 32'd0, {31'b0, resultValid});
    for (int i = 0; i < caseName.size(); i++) begin
      runCase(i);
    end
    // Let the last valid pulse pass before the burst
    @(negedge clk);
    runBurst();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+testbench
rtl/mulDivPkg.sv
rtl/pipelinedMultiplier.sv
rtl/restoringDivider.sv
rtl/resultSelect.sv
rtl/mulDivUnit.sv
testbench/mulDivTb.sv
